//--- all.f
verilog/ad9361_pkg.sv
verilog/iq_pair_formatter.sv
verilog/axis_burst_framer.sv
verilog/ad9361_dual_axis.sv
sim/ad9361_dual_axis_asserts.sv
sim/tb_ad9361_dual_axis.sv

//--- sim/ad9361_dual_axis_asserts.sv
// checks only the axi-stream master side; bound into every ad9361_dual_axis instance

`timescale 1ns/100ps

module ad9361_dual_axis_asserts (
  input logic              m_axis_clk,
  input logic              reset,
  input logic              m_axis_tready,
  input logic              m_axis_tvalid,
  input ad9361_pkg::beat_t m_axis_tdata,
  input logic              m_axis_tlast,
  input logic              overrun
);

  int fail_count = 0;

  // held beat must not change under back-pressure
  tdata_stable: assert property (
    @(posedge m_axis_clk) disable iff (reset)
    (m_axis_tvalid && !m_axis_tready) |=> $stable(m_axis_tdata)
  ) else begin
    $error("tdata changed while the beat was stalled");
    fail_count++;
  end

  // no withdrawal of a beat before its transfer
  tvalid_held: assert property (
    @(posedge m_axis_clk) disable iff (reset)
    (m_axis_tvalid && !m_axis_tready) |=> m_axis_tvalid
  ) else begin
    $error("tvalid fell before the beat transferred");
    fail_count++;
  end

  tlast_with_tvalid: assert property (
    @(posedge m_axis_clk) disable iff (reset)
    m_axis_tlast |-> m_axis_tvalid
  ) else begin
    $error("tlast high without tvalid");
    fail_count++;
  end

  // control outputs come out of reset low
  reset_state: assert property (
    @(posedge m_axis_clk)
    reset |=> (!m_axis_tvalid && !m_axis_tlast && !overrun)
  ) else begin
    $error("control outputs not low after reset");
    fail_count++;
  end

endmodule

bind ad9361_dual_axis ad9361_dual_axis_asserts protocol_checks (
  .m_axis_clk    (m_axis_clk),
  .reset         (reset),
  .m_axis_tready (m_axis_tready),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tdata  (m_axis_tdata),
  .m_axis_tlast  (m_axis_tlast),
  .overrun       (overrun)
);

//--- sim/tb_ad9361_dual_axis.sv
// built with burst_length 4 and one transfer per table row, so tlast lands on rows 3 and 7

`timescale 1ns/100ps

module tb_ad9361_dual_axis;

  localparam int num_rows       = 8;
  localparam int timeout_cycles = 20;

  typedef logic [ad9361_pkg::beat_bits-1:0] word_t;

  // stimulus, tready pattern and expected results of one table row
  typedef struct packed {
    logic [3:0]                   valid;
    ad9361_pkg::iq_sample_t [3:0] iq;
    logic                         reverse;
    logic [3:0]                   stall;
    logic                         extra;
    ad9361_pkg::beat_t            beat;
    logic                         tlast;
    logic                         overrun;
  } row_t;

  logic                   m_axis_clk;
  logic                   reset;
  logic                   valid_0;
  logic                   valid_1;
  logic                   valid_2;
  logic                   valid_3;
  ad9361_pkg::iq_sample_t iq_0;
  ad9361_pkg::iq_sample_t iq_1;
  ad9361_pkg::iq_sample_t iq_2;
  ad9361_pkg::iq_sample_t iq_3;
  logic                   reverse;
  logic                   m_axis_tready;
  logic                   m_axis_tvalid;
  ad9361_pkg::beat_t      m_axis_tdata;
  logic                   m_axis_tlast;
  logic                   overrun;

  row_t  rows [num_rows];
  string row_names [num_rows];

  // model copies of the half registers inside each formatter
  ad9361_pkg::half_beat_t model_a;
  ad9361_pkg::half_beat_t model_b;

  int passed;
  int failed;
  int row_errors;
  bit timed_out;

  ad9361_dual_axis #(
    .burst_length (4)
  ) UUT (
    .m_axis_clk    (m_axis_clk),
    .reset         (reset),
    .valid_0       (valid_0),
    .iq_0          (iq_0),
    .valid_1       (valid_1),
    .iq_1          (iq_1),
    .valid_2       (valid_2),
    .iq_2          (iq_2),
    .valid_3       (valid_3),
    .iq_3          (iq_3),
    .reverse       (reverse),
    .m_axis_tready (m_axis_tready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .overrun       (overrun)
  );

  initial m_axis_clk = 1'b0;
  always #50 m_axis_clk = ~m_axis_clk;

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic [ad9361_pkg::precision-1:0] reduce_sample(
    input logic signed [ad9361_pkg::adc_bits-1:0] x
  );
    logic signed [ad9361_pkg::adc_bits-1:0] shifted;
    shifted = x >>> ad9361_pkg::reduce_bits;
    return shifted[ad9361_pkg::precision-1:0];
  endfunction

  // slot 0 up holds i lo, q lo, i hi and q hi unless reverse mirrors them
  function automatic ad9361_pkg::half_beat_t pack_half(
    input ad9361_pkg::iq_sample_t lo,
    input ad9361_pkg::iq_sample_t hi,
    input logic                   rev
  );
    logic [3:0][ad9361_pkg::precision-1:0] natural_order;
    ad9361_pkg::half_beat_t                h;
    natural_order[0] = reduce_sample(lo.i);
    natural_order[1] = reduce_sample(lo.q);
    natural_order[2] = reduce_sample(hi.i);
    natural_order[3] = reduce_sample(hi.q);
    for (int k = 0; k < 4; k++) begin
      h.slot[k] = rev ? natural_order[3-k] : natural_order[k];
    end
    return h;
  endfunction

  task automatic add_row(input int n, input string name, input logic [3:0] valid,
                         input logic rev, input logic [3:0] stall, input logic extra,
                         input logic tlast, input logic ovr);
    row_t        r;
    logic [31:0] rnd;
    r.valid   = valid;
    r.reverse = rev;
    r.stall   = stall;
    r.extra   = extra;
    r.tlast   = tlast;
    r.overrun = ovr;
    for (int k = 0; k < 4; k++) begin
      rnd = $urandom;
      r.iq[k] = rnd[23:0];
    end
    // a silent port keeps its previous half
    if (valid[0] || valid[1]) model_a = pack_half(r.iq[0], r.iq[1], rev);
    if (valid[2] || valid[3]) model_b = pack_half(r.iq[2], r.iq[3], rev);
    r.beat.upper = rev ? model_a : model_b;
    r.beat.lower = rev ? model_b : model_a;
    // dropped frame still reloads both formatter halves
    if (extra) begin
      model_a = pack_half(~r.iq[0], ~r.iq[1], rev);
      model_b = pack_half(~r.iq[2], ~r.iq[3], rev);
    end
    rows[n]      = r;
    row_names[n] = name;
  endtask

  ////////////////////
  // drive and check
  ////////////////////

  task automatic drive_inputs(input logic [3:0] v, input ad9361_pkg::iq_sample_t [3:0] iq);
    valid_0 = v[0];
    valid_1 = v[1];
    valid_2 = v[2];
    valid_3 = v[3];
    iq_0    = iq[0];
    iq_1    = iq[1];
    iq_2    = iq[2];
    iq_3    = iq[3];
  endtask

  task automatic step();
    @(posedge m_axis_clk);
    #10;
  endtask

  task automatic report_mismatch(input string name, input word_t exp, input word_t got);
    $display("ERR %s expected %0h got %0h", name, exp, got);
    row_errors++;
  endtask

  task automatic close_test(input string name);
    if (row_errors == 0) begin
      passed++;
      $display("test %s passed", name);
    end else begin
      failed++;
      $display("test %s failed with %0d errors", name, row_errors);
    end
  endtask

  task automatic run_row(input int n);
    row_t r;
    int   latency;
    r          = rows[n];
    row_errors = 0;
    reverse       = r.reverse;
    m_axis_tready = (r.stall == 0);
    drive_inputs(r.valid, r.iq);
    latency = 0;
    // valids last one cycle and tvalid follows two cycles later
    do begin
      step();
      latency++;
      drive_inputs(4'b0000, r.iq);
    end while (!m_axis_tvalid && latency < timeout_cycles);
    if (!m_axis_tvalid) begin
      $display("row %0d: tvalid did not rise within %0d cycles", n, timeout_cycles);
      timed_out = 1'b1;
      row_errors++;
      return;
    end
    if (latency != 2) begin
      $display("row %0d: tvalid rose after %0d cycles instead of 2", n, latency);
      row_errors++;
    end
    if (m_axis_tdata !== r.beat) report_mismatch("m_axis_tdata", r.beat, m_axis_tdata);
    if (m_axis_tlast !== r.tlast) report_mismatch("m_axis_tlast", r.tlast, m_axis_tlast);
    // stalled cycles with an optional frame that must be dropped
    for (int s = 0; s < r.stall; s++) begin
      if (r.extra && s == 0) drive_inputs(4'b1111, ~r.iq);
      step();
      drive_inputs(4'b0000, r.iq);
      if (m_axis_tvalid !== 1'b1) report_mismatch("m_axis_tvalid", 1, m_axis_tvalid);
      if (m_axis_tdata !== r.beat) report_mismatch("m_axis_tdata", r.beat, m_axis_tdata);
      if (m_axis_tlast !== r.tlast) report_mismatch("m_axis_tlast", r.tlast, m_axis_tlast);
    end
    if (r.extra && overrun !== 1'b1) report_mismatch("overrun", 1, overrun);
    m_axis_tready = 1'b1;
    step();
    if (m_axis_tvalid !== 1'b0) report_mismatch("m_axis_tvalid", 0, m_axis_tvalid);
    if (overrun !== r.overrun) report_mismatch("overrun", r.overrun, overrun);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    reset         = 1'b1;
    reverse       = 1'b0;
    m_axis_tready = 1'b0;
    drive_inputs(4'b0000, '0);
    passed    = 0;
    failed    = 0;
    timed_out = 1'b0;
    model_a   = '0;
    model_b   = '0;
    void'($urandom(32'hf6f2));

    add_row(0, "normal packing", 4'b1111, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0);
    add_row(1, "reverse order", 4'b1111, 1'b1, 4'd0, 1'b0, 1'b0, 1'b0);
    add_row(2, "normal with stall", 4'b1111, 1'b0, 4'd2, 1'b0, 1'b0, 1'b0);
    add_row(3, "partial frame port b", 4'b0100, 1'b0, 4'd0, 1'b0, 1'b1, 1'b0);
    add_row(4, "back-pressure overrun", 4'b1111, 1'b0, 4'd3, 1'b1, 1'b0, 1'b1);
    add_row(5, "overrun sticky", 4'b1111, 1'b0, 4'd1, 1'b0, 1'b0, 1'b1);
    add_row(6, "partial frame port a", 4'b0001, 1'b0, 4'd0, 1'b0, 1'b0, 1'b1);
    add_row(7, "reverse burst end", 4'b1111, 1'b1, 4'd2, 1'b0, 1'b1, 1'b1);

    repeat (3) @(posedge m_axis_clk);
    #10;
    reset = 1'b0;

    // reset state over two cycles
    row_errors = 0;
    for (int c = 0; c < 2; c++) begin
      if (m_axis_tvalid !== 1'b0) report_mismatch("m_axis_tvalid", 0, m_axis_tvalid);
      if (m_axis_tlast !== 1'b0) report_mismatch("m_axis_tlast", 0, m_axis_tlast);
      if (overrun !== 1'b0) report_mismatch("overrun", 0, overrun);
      step();
    end
    close_test("reset state");

    for (int n = 0; n < num_rows && !timed_out; n++) begin
      run_row(n);
      close_test(row_names[n]);
    end

    $display("%0d tests passed, %0d tests failed, %0d assertion failures",
             passed, failed, UUT.protocol_checks.fail_count);
    if (failed == 0 && !timed_out && UUT.protocol_checks.fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- verilog/ad9361_dual_axis.sv
// dual-channel ad9361 receive to axi-stream, two cycles valid to tvalid, single clock only

`timescale 1ns/100ps

module ad9361_dual_axis #(
  parameter int burst_length = ad9361_pkg::default_burst_length
) (
  input  logic                   m_axis_clk,
  input  logic                   reset,

  // four receive streams, each with its own strobe
  input  logic                   valid_0,
  input  ad9361_pkg::iq_sample_t iq_0,
  input  logic                   valid_1,
  input  ad9361_pkg::iq_sample_t iq_1,
  input  logic                   valid_2,
  input  ad9361_pkg::iq_sample_t iq_2,
  input  logic                   valid_3,
  input  ad9361_pkg::iq_sample_t iq_3,

  // static slot order select
  input  logic                   reverse,

  // axi-stream master
  input  logic                   m_axis_tready,
  output logic                   m_axis_tvalid,
  output ad9361_pkg::beat_t      m_axis_tdata,
  output logic                   m_axis_tlast,

  output logic                   overrun
);

  ad9361_pkg::half_beat_t half_a;
  ad9361_pkg::half_beat_t half_b;
  logic                   frame_a;
  logic                   frame_b;

  ////////////////////
  // formatters
  ////////////////////

  // port a, streams 0 and 1
  iq_pair_formatter port_a (
    .m_axis_clk (m_axis_clk),
    .reset      (reset),
    .valid_lo   (valid_0),
    .iq_lo      (iq_0),
    .valid_hi   (valid_1),
    .iq_hi      (iq_1),
    .reverse    (reverse),
    .half       (half_a),
    .frame      (frame_a)
  );

  // port b, streams 2 and 3
  iq_pair_formatter port_b (
    .m_axis_clk (m_axis_clk),
    .reset      (reset),
    .valid_lo   (valid_2),
    .iq_lo      (iq_2),
    .valid_hi   (valid_3),
    .iq_hi      (iq_3),
    .reverse    (reverse),
    .half       (half_b),
    .frame      (frame_b)
  );

  ////////////////////
  // framer
  ////////////////////

  axis_burst_framer #(
    .burst_length (burst_length)
  ) framer (
    .m_axis_clk    (m_axis_clk),
    .reset         (reset),
    .half_a        (half_a),
    .half_b        (half_b),
    .frame_a       (frame_a),
    .frame_b       (frame_b),
    .reverse       (reverse),
    .m_axis_tready (m_axis_tready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .overrun       (overrun)
  );

endmodule

//--- verilog/ad9361_pkg.sv
// shared sizing and payload types; precision fixed at 12 bits, adc samples are signed 12-bit

package ad9361_pkg;

  ////////////////////
  // sizing
  ////////////////////

  // width of one converter sample
  localparam int adc_bits = 12;

  // bits kept per packed sample
  localparam int precision = 12;

  // arithmetic right shift applied to each sample before packing
  localparam int reduce_bits = adc_bits - precision;

  // samples carried by one formatter
  localparam int slots_per_half = 4;

  // full tdata width, two halves of four slots each
  localparam int beat_bits = 2 * slots_per_half * precision;

  // beats per burst unless the top level overrides it
  localparam int default_burst_length = 16;

  ////////////////////
  // payload types
  ////////////////////

  // raw input of one stream, i in the low bits
  typedef struct packed {
    logic signed [adc_bits-1:0] q;
    logic signed [adc_bits-1:0] i;
  } iq_sample_t;

  // one formatter's output, slot 0 in the low bits
  typedef struct packed {
    logic [slots_per_half-1:0][precision-1:0] slot;
  } half_beat_t;

  // tdata content, port a normally in the lower half
  typedef struct packed {
    half_beat_t upper;
    half_beat_t lower;
  } beat_t;

endpackage

//--- verilog/axis_burst_framer.sv
// single clock, no handshake toward the formatters; frames arriving during a stall are lost

`timescale 1ns/100ps

module axis_burst_framer #(
  parameter int burst_length = ad9361_pkg::default_burst_length
) (
  input  logic                   m_axis_clk,
  input  logic                   reset,

  // half-beats and strobes from the two formatters
  input  ad9361_pkg::half_beat_t half_a,
  input  ad9361_pkg::half_beat_t half_b,
  input  logic                   frame_a,
  input  logic                   frame_b,

  // swaps the halves together with the per-port slot reversal
  input  logic                   reverse,

  // axi-stream master
  input  logic                   m_axis_tready,
  output logic                   m_axis_tvalid,
  output ad9361_pkg::beat_t      m_axis_tdata,
  output logic                   m_axis_tlast,

  // sticky, cleared only by reset
  output logic                   overrun
);

  // one bit minimum so a burst of one still builds
  localparam int count_bits = (burst_length > 1) ? $clog2(burst_length) : 1;
  localparam logic [count_bits-1:0] last_count = count_bits'(burst_length - 1);

  logic frame_any;
  logic stalled;
  logic transfer;
  logic load;
  logic drop;
  logic end_burst;

  logic [ad9361_pkg::beat_bits-1:0] merged;
  logic [count_bits-1:0]            beat_count;

  ////////////////////
  // flow control
  ////////////////////

  // either port strobing starts a frame, the other half is reused
  assign frame_any = frame_a | frame_b;

  assign stalled  = m_axis_tvalid & ~m_axis_tready;
  assign transfer = m_axis_tvalid & m_axis_tready;

  // a held beat blocks the load, the new frame is dropped
  assign load = frame_any & ~stalled;
  assign drop = frame_any & stalled;

  ////////////////////
  // beat assembly
  ////////////////////

  // port a low unless reversed
  assign merged = reverse ? {half_a, half_b} : {half_b, half_a};

  always_ff @(posedge m_axis_clk) begin
    if (load) begin
      m_axis_tdata <= ad9361_pkg::beat_t'(merged);
    end
  end

  // tvalid drops after a transfer unless a new beat loads in that cycle
  always_ff @(posedge m_axis_clk) begin
    if (reset) begin
      m_axis_tvalid <= 1'b0;
    end else if (load) begin
      m_axis_tvalid <= 1'b1;
    end else if (transfer) begin
      m_axis_tvalid <= 1'b0;
    end
  end

  always_ff @(posedge m_axis_clk) begin
    if (reset) begin
      overrun <= 1'b0;
    end else if (drop) begin
      overrun <= 1'b1;
    end
  end

  ////////////////////
  // burst count
  ////////////////////

  assign end_burst = (beat_count == last_count);

  // advance only on a transfer, wrap after the last beat
  always_ff @(posedge m_axis_clk) begin
    if (reset) begin
      beat_count <= '0;
    end else if (transfer) begin
      if (end_burst) begin
        beat_count <= '0;
      end else begin
        beat_count <= beat_count + 1'b1;
      end
    end
  end

  assign m_axis_tlast = m_axis_tvalid & end_burst;

endmodule

//--- verilog/iq_pair_formatter.sv
// one port of two i/q streams; reverse must stay static while frames are in flight

`timescale 1ns/100ps

module iq_pair_formatter (
  input  logic                   m_axis_clk,
  input  logic                   reset,

  // stream pair from one transceiver port
  input  logic                   valid_lo,
  input  ad9361_pkg::iq_sample_t iq_lo,
  input  logic                   valid_hi,
  input  ad9361_pkg::iq_sample_t iq_hi,

  // slot order select
  input  logic                   reverse,

  // registered half-beat and its one-cycle strobe
  output ad9361_pkg::half_beat_t half,
  output logic                   frame
);

  logic any_valid;

  // samples in natural slot order before truncation
  logic signed [ad9361_pkg::adc_bits-1:0] shifted [ad9361_pkg::slots_per_half];

  // reduced samples, natural order and final order
  logic [ad9361_pkg::slots_per_half-1:0][ad9361_pkg::precision-1:0] natural;
  logic [ad9361_pkg::slots_per_half-1:0][ad9361_pkg::precision-1:0] ordered;

  assign any_valid = valid_lo | valid_hi;

  ////////////////////
  // precision
  ////////////////////

  // sign is kept by the arithmetic shift
  always_comb begin
    shifted[0] = iq_lo.i >>> ad9361_pkg::reduce_bits;
    shifted[1] = iq_lo.q >>> ad9361_pkg::reduce_bits;
    shifted[2] = iq_hi.i >>> ad9361_pkg::reduce_bits;
    shifted[3] = iq_hi.q >>> ad9361_pkg::reduce_bits;
  end

  ////////////////////
  // slot order
  ////////////////////

  always_comb begin
    for (int k = 0; k < ad9361_pkg::slots_per_half; k++) begin
      natural[k] = shifted[k][ad9361_pkg::precision-1:0];
    end
    // reverse mirrors the four slots of this half
    for (int k = 0; k < ad9361_pkg::slots_per_half; k++) begin
      if (reverse) begin
        ordered[k] = natural[ad9361_pkg::slots_per_half-1-k];
      end else begin
        ordered[k] = natural[k];
      end
    end
  end

  ////////////////////
  // output registers
  ////////////////////

  // strobe follows any valid by one cycle
  always_ff @(posedge m_axis_clk) begin
    if (reset) begin
      frame <= 1'b0;
    end else begin
      frame <= any_valid;
    end
  end

  // half holds between strobes so a silent port keeps its last samples
  always_ff @(posedge m_axis_clk) begin
    if (any_valid) begin
      half.slot <= ordered;
    end
  end

endmodule
